/* src/bubble_pkg.sv */
`default_nettype none

package bubble_pkg;

    // access type codes as seen on the bubble bus
    localparam logic [2:0] acc_idle = 3'b000; // nothing running
    localparam logic [2:0] acc_boot = 3'b110; // boot loop
    localparam logic [2:0] acc_user = 3'b111; // user page

    // buffer geometry
    localparam int buf_addr_w  = 13;               // one channel buffer, 8192 bits
    localparam int bit_addr_w  = 15;               // host bit address
    localparam int byte_addr_w = 12;               // host byte address
    localparam int buf_depth   = 1 << buf_addr_w;

    // parked read address when no boot or user access runs
    localparam logic [buf_addr_w-1:0] idle_read_addr = '1;

    // user pages sit in the top 1k of the buffer, base 7168
    localparam logic [2:0] user_page_base = 3'b111;

    // sequence lengths in output cycles
    localparam int boot_len = 4106; // filler, sync, bootloader, filler
    localparam int user_len = 584;  // 3 shifted bits plus page data

    // mclk cycles per output tick
    localparam int tick_div = 4;
    localparam int div_w    = $clog2(tick_div);

endpackage

`default_nettype wire

/* src/bubble_page_loader.sv */
`timescale 1ns/1ps
`default_nettype none

// host byte in, eight single-bit buffer writes out, lsb first
module bubble_page_loader
    import bubble_pkg::*;
(
    input  wire                    mclk,
    input  wire                    rst,

    // host side
    input  wire                    load_valid,
    input  wire [byte_addr_w-1:0]  load_addr,
    input  wire [7:0]              load_byte,
    output logic                   load_busy,

    // outbuffer write port
    output logic                   wr_en,
    output logic [bit_addr_w-1:0]  wr_addr,
    output logic                   wr_data
);

    logic                   busy_q;   // serializing in progress
    logic [2:0]             bit_cnt;  // which byte bit goes out now
    logic [7:0]             byte_sr;  // shifts right, bit 0 on wr_data
    logic [byte_addr_w-1:0] base_q;   // latched byte address
    logic                   accept;

    assign accept = load_valid && !busy_q; // strobes while busy are dropped

    // control state
    always_ff @(posedge mclk)
    begin
        if (rst)
        begin
            busy_q  <= 1'b0;
            bit_cnt <= '0;
        end
        else if (accept)
        begin
            busy_q  <= 1'b1;
            bit_cnt <= '0;
        end
        else if (busy_q)
        begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
                busy_q <= 1'b0; // last bit written on this edge
            end
        end
    end

    // byte shifter and address latch
    always_ff @(posedge mclk)
    begin
        if (accept)
        begin
            byte_sr <= load_byte;
            base_q  <= load_addr;
        end
        else if (busy_q)
        begin
            byte_sr <= {1'b0, byte_sr[7:1]};
        end
    end

    assign load_busy = busy_q;
    assign wr_en     = busy_q;             // one write per busy cycle
    assign wr_addr   = {base_q, bit_cnt};  // byte address times 8 plus bit
    assign wr_data   = byte_sr[0];

endmodule

`default_nettype wire

/* src/bubble_cycle_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// replays one boot or user access as a train of output cycles
module bubble_cycle_sequencer
    import bubble_pkg::*;
(
    input  wire                   mclk,
    input  wire                   rst,

    // access request
    input  wire                   req,
    input  wire [2:0]             req_type,
    output logic                  seq_busy,

    // to outbuffer
    output logic [2:0]            acc_type,
    output logic [buf_addr_w-1:0] cycle_num,
    output logic                  bout_tick
);

    logic                  busy_q;
    logic [2:0]            type_q;     // acc_idle whenever not busy
    logic [div_w-1:0]      div_q;      // mclk count inside one output cycle
    logic [buf_addr_w-1:0] cyc_q;      // current output cycle
    logic [buf_addr_w-1:0] last_cyc;   // end count for the running type
    logic                  type_ok;
    logic                  start;
    logic                  tick;

    // only boot and user are real accesses
    assign type_ok = (req_type == acc_boot) || (req_type == acc_user);
    assign start   = req && !busy_q && type_ok;

    // end count picked from the latched type
    assign last_cyc = (type_q == acc_boot) ? buf_addr_w'(boot_len - 1)
                                           : buf_addr_w'(user_len - 1);

    // read strobe on the last divider step
    assign tick = busy_q && (div_q == div_w'(tick_div - 1));

    always_ff @(posedge mclk)
    begin
        if (rst)
        begin
            busy_q <= 1'b0;
            type_q <= acc_idle;
            div_q  <= '0;
            cyc_q  <= '0;
        end
        else if (start)
        begin
            busy_q <= 1'b1;
            type_q <= req_type;
            div_q  <= '0;
            cyc_q  <= '0;    // first cycle is number 0
        end
        else if (busy_q)
        begin
            if (tick)
            begin
                div_q <= '0;
                if (cyc_q == last_cyc)
                begin
                    // last read issued, back to idle
                    busy_q <= 1'b0;
                    type_q <= acc_idle;
                    cyc_q  <= '0;
                end
                else
                begin
                    cyc_q <= cyc_q + 1'b1; // next output cycle
                end
            end
            else
            begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    assign seq_busy  = busy_q;
    assign acc_type  = type_q;
    assign cycle_num = cyc_q;
    assign bout_tick = tick;

endmodule

`default_nettype wire

/* src/bubble_outbuffer.sv */
`timescale 1ns/1ps
`default_nettype none

// two 8192x1 channel buffers, written bitwise by the loader and read
// out once per output tick as inverted serial streams
module bubble_outbuffer
    import bubble_pkg::*;
(
    input  wire                    mclk,
    input  wire                    rst,

    // read side, from the sequencer
    input  wire [2:0]              acc_type,
    input  wire [buf_addr_w-1:0]   cycle_num,
    input  wire                    bout_tick,

    // write side, from the loader
    input  wire                    wr_en,
    input  wire [bit_addr_w-1:0]   wr_addr,
    input  wire                    wr_data,

    // bubble data out
    output logic                   dout0,
    output logic                   dout1,
    output logic                   dout_valid
);

    logic                  wr_sel;      // 0 = dout0 buffer, 1 = dout1 buffer
    logic [buf_addr_w-1:0] wr_loc;
    logic [buf_addr_w-1:0] rd_addr;
    logic                  rd_pend_q;   // read data lands this cycle
    logic                  valid_q;
    wire  [1:0]            ch_dout;     // per channel, already inverted

    // write decode, bit 0 picks the channel, bit 14 unused in 2-bit mode
    assign wr_sel = wr_addr[0];
    assign wr_loc = wr_addr[buf_addr_w:1];

    // read address decode
    always_comb
    begin
        case (acc_type)
            acc_boot:
            begin
                rd_addr = cycle_num;                          // whole buffer
            end
            acc_user:
            begin
                rd_addr = {user_page_base, cycle_num[9:0]};   // page window at 7168
            end
            default:
            begin
                rd_addr = idle_read_addr;                     // parked on last location
            end
        endcase
    end

    genvar ch;
    generate
        for (ch = 0; ch < 2; ch++)
        begin : g_chan
            logic mem [0:buf_depth-1];  // buffer contents keep across reset
            logic rd_bit;               // sampled at the tick
            logic out_bit;              // presented one cycle later

            always_ff @(posedge mclk)
            begin
                if (wr_en && (wr_sel == 1'(ch)))
                begin
                    mem[wr_loc] <= wr_data;
                end
            end

            always_ff @(posedge mclk)
            begin
                if (rst)
                begin
                    rd_bit  <= 1'b0;
                    out_bit <= 1'b0;    // cleared, so the pin idles high
                end
                else
                begin
                    if (bout_tick)
                    begin
                        rd_bit <= mem[rd_addr];
                    end
                    if (rd_pend_q)
                    begin
                        out_bit <= rd_bit;
                    end
                end
            end

            assign ch_dout[ch] = ~out_bit; // bubble lines are active low
        end
    endgenerate

    // valid follows the tick by two edges
    always_ff @(posedge mclk)
    begin
        if (rst)
        begin
            rd_pend_q <= 1'b0;
            valid_q   <= 1'b0;
        end
        else
        begin
            rd_pend_q <= bout_tick;
            valid_q   <= rd_pend_q;
        end
    end

    assign dout0      = ch_dout[0];
    assign dout1      = ch_dout[1];
    assign dout_valid = valid_q;

endmodule

`default_nettype wire

/* src/bubble_emulator_top.sv */
`timescale 1ns/1ps
`default_nettype none

// bubble cartridge data path, host load port in and serial streams out
module bubble_emulator_top
    import bubble_pkg::*;
(
    input  wire                    mclk,
    input  wire                    rst,

    // host image load
    input  wire                    load_valid,
    input  wire [byte_addr_w-1:0]  load_addr,
    input  wire [7:0]              load_byte,
    output logic                   load_busy,

    // access request
    input  wire                    req,
    input  wire [2:0]              req_type,
    output logic                   seq_busy,

    // bubble data out
    output logic                   dout0,
    output logic                   dout1,
    output logic                   dout_valid
);

    // loader to outbuffer
    logic                  wr_en;
    logic [bit_addr_w-1:0] wr_addr;
    logic                  wr_data;

    // sequencer to outbuffer
    logic [2:0]            acc_type;
    logic [buf_addr_w-1:0] cycle_num;
    logic                  bout_tick;

    bubble_page_loader u_loader (
        .mclk       (mclk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_byte  (load_byte),
        .load_busy  (load_busy),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    bubble_cycle_sequencer u_seq (
        .mclk      (mclk),
        .rst       (rst),
        .req       (req),
        .req_type  (req_type),
        .seq_busy  (seq_busy),
        .acc_type  (acc_type),
        .cycle_num (cycle_num),
        .bout_tick (bout_tick)
    );

    bubble_outbuffer u_outbuf (
        .mclk       (mclk),
        .rst        (rst),
        .acc_type   (acc_type),
        .cycle_num  (cycle_num),
        .bout_tick  (bout_tick),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .dout0      (dout0),
        .dout1      (dout1),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

/* tb/bubble_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// pin level timing checks, bound into bubble_emulator_top
module bubble_assertions (
    input wire mclk,
    input wire rst,
    input wire load_busy,
    input wire dout0,
    input wire dout1,
    input wire dout_valid
);

    logic [3:0] busy_run; // consecutive busy samples before this edge

    always_ff @(posedge mclk)
    begin
        if (rst || !load_busy)
        begin
            busy_run <= '0;
        end
        else
        begin
            busy_run <= busy_run + 4'd1;
        end
    end

    // ticks are tick_div apart, so valid is always a single cycle
    a_valid_single: assert property (@(posedge mclk) disable iff (rst)
        dout_valid |=> !dout_valid)
        else $error("dout_valid high on two consecutive cycles");

    a_busy_max: assert property (@(posedge mclk) disable iff (rst)
        load_busy |-> busy_run < 4'd8)  // a ninth busy cycle trips this
        else $error("load_busy high for more than eight cycles");

    a_busy_min: assert property (@(posedge mclk) disable iff (rst)
        $fell(load_busy) |-> busy_run == 4'd8)
        else $error("load_busy dropped before eight cycles");

    // outputs only move on the edge that raises valid
    a_dout_hold: assert property (@(posedge mclk) disable iff (rst)
        $changed({dout0, dout1}) |-> dout_valid)
        else $error("dout changed outside a dout_valid cycle");

endmodule

`default_nettype wire

/* tb/tb_bubble.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bubble
    import bubble_pkg::*;
();

    logic                   mclk;
    logic                   rst;
    logic                   load_valid;
    logic [byte_addr_w-1:0] load_addr;
    logic [7:0]             load_byte;
    logic                   req;
    logic [2:0]             req_type;
    wire                    load_busy;
    wire                    seq_busy;
    wire                    dout0;
    wire                    dout1;
    wire                    dout_valid;

    logic [7:0] image [0:(1 << byte_addr_w)-1];     // host image, 32768 bits
    logic       buf_model [0:(1 << (bit_addr_w-1))-1]; // buffer contents by bit address
    integer     seed;

    bubble_emulator_top dut (
        .mclk       (mclk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_byte  (load_byte),
        .load_busy  (load_busy),
        .req        (req),
        .req_type   (req_type),
        .seq_busy   (seq_busy),
        .dout0      (dout0),
        .dout1      (dout1),
        .dout_valid (dout_valid)
    );

    bind bubble_emulator_top bubble_assertions u_assertions (
        .mclk       (mclk),
        .rst        (rst),
        .load_busy  (load_busy),
        .dout0      (dout0),
        .dout1      (dout1),
        .dout_valid (dout_valid)
    );

    always #4 mclk = ~mclk; // 8 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string what);
        abort_run($sformatf("Error at %0d ns: %s", $time, what));
    endtask

    // inputs move 1 ns after the rising edge, outputs are read there too
    task automatic next_edge();
        @(posedge mclk);
        #1;
    endtask

    task automatic wait_load_idle();
        int n = 0;
        while (load_busy)
        begin
            next_edge();
            n++;
            if (n > 20)
                abort_run("timeout: load_busy never went low");
        end
    endtask

    task automatic wait_seq_idle();
        int n = 0;
        while (seq_busy)
        begin
            next_edge();
            n++;
            if (n > boot_len * tick_div + 20)
                abort_run("timeout: seq_busy never went low");
        end
    endtask

    // byte bit i lands at bit address addr*8+i, bit 14 not decoded
    task automatic model_write(input int addr, input logic [7:0] data);
        logic [bit_addr_w-1:0] ba;
        for (int i = 0; i < 8; i++)
        begin
            ba = bit_addr_w'(addr * 8 + i);
            buf_model[ba[bit_addr_w-2:0]] = data[i];
        end
    endtask

    task automatic load_one(input int addr, input logic [7:0] data);
        wait_load_idle();
        load_valid = 1'b1;
        load_addr  = byte_addr_w'(addr);
        load_byte  = data;
        next_edge();
        load_valid = 1'b0;
        assert (load_busy) else value_error($sformatf("load of byte %0d not taken", addr));
        model_write(addr, data);
    endtask

    // bit 0 of the bit address picks the channel
    task automatic check_pair(input int addr);
        assert (dout0 == ~buf_model[2 * addr])
        else value_error($sformatf("dout0 wrong at read address %0d", addr));
        assert (dout1 == ~buf_model[2 * addr + 1])
        else value_error($sformatf("dout1 wrong at read address %0d", addr));
    endtask

    // one access, counts and checks every valid pulse
    task automatic run_access(input logic [2:0] typ, input int len, input bit poke);
        int pulses = 0;
        int cycles = 0;
        int addr;
        wait_seq_idle();
        req      = 1'b1;
        req_type = typ;
        next_edge();
        req      = 1'b0;
        req_type = acc_user; // used by the mid access request
        assert (seq_busy) else value_error("seq_busy low after an accepted req");
        while (pulses < len)
        begin
            next_edge();
            cycles++;
            if (cycles > len * tick_div + 10)
                abort_run($sformatf("timeout: only %0d of %0d pulses seen", pulses, len));
            if (dout_valid)
            begin
                addr = (typ == acc_boot) ? pulses : 7168 + pulses; // user page window
                check_pair(addr);
                pulses++;
            end
            req = poke && (pulses == 100); // ignored, access already running
        end
        req = 1'b0;
        assert (!seq_busy) else value_error("seq_busy high after the last pulse");
        repeat (2 * tick_div)
        begin
            next_edge();
            assert (!dout_valid) else value_error("dout_valid after the access ended");
        end
    endtask

    // second strobe while busy targets the next byte and must be dropped
    task automatic overlap_load(input int addr);
        logic [7:0] cur0;
        logic [7:0] cur1;
        int         edges;
        for (int i = 0; i < 8; i++)
        begin
            cur0[i] = buf_model[addr * 8 + i];
            cur1[i] = buf_model[(addr + 1) * 8 + i];
        end
        wait_load_idle();
        load_valid = 1'b1;
        load_addr  = byte_addr_w'(addr);
        load_byte  = ~cur0;
        next_edge();
        load_addr  = byte_addr_w'(addr + 1);
        load_byte  = ~cur1;
        next_edge();
        load_valid = 1'b0;
        edges = 2;
        while (load_busy)
        begin
            next_edge();
            edges++;
            if (edges > 20)
                abort_run("timeout: load_busy stuck after overlapping load");
        end
        assert (edges == 9) else value_error($sformatf("busy fell %0d edges after load", edges));
        model_write(addr, ~cur0); // only the first byte counts
    endtask

    task automatic bad_request(input logic [2:0] typ);
        logic d0;
        logic d1;
        wait_seq_idle();
        d0       = dout0;
        d1       = dout1;
        req      = 1'b1;
        req_type = typ;
        next_edge();
        req      = 1'b0;
        repeat (20)
        begin
            assert (!seq_busy && !dout_valid)
            else value_error($sformatf("req type %b started an access", typ));
            assert (dout0 == d0 && dout1 == d1) else value_error("dout moved while idle");
            next_edge();
        end
    endtask

    initial
    begin
        seed       = 32'h995e_1304;
        mclk       = 1'b0;
        rst        = 1'b1;
        load_valid = 1'b0;
        load_addr  = '0;
        load_byte  = '0;
        req        = 1'b0;
        req_type   = acc_idle;
        repeat (5) @(posedge mclk);
        #1;
        rst = 1'b0;
        assert (!load_busy && !seq_busy && !dout_valid) else value_error("busy or valid after reset");
        assert (dout0 && dout1) else value_error("dout not high after reset");
        for (int a = 0; a < (1 << byte_addr_w); a++)
        begin
            image[a] = 8'($random(seed));
        end
        for (int a = 0; a < (1 << byte_addr_w); a++)
        begin
            load_one(a, image[a]); // upper half overwrites lower, bit 14 unused
        end
        run_access(acc_boot, boot_len, 1'b0);
        run_access(acc_user, user_len, 1'b0);
        bad_request(3'b101);
        bad_request(acc_idle);
        overlap_load(37);
        run_access(acc_boot, boot_len, 1'b1); // with a second req mid access
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/bubble_pkg.sv
src/bubble_page_loader.sv
src/bubble_cycle_sequencer.sv
src/bubble_outbuffer.sv
src/bubble_emulator_top.sv
tb/bubble_assertions.sv
tb/tb_bubble.sv

/* run.sh */
#!/bin/sh
# build and run the bubble emulator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_bubble \
    -f flist.f -o sim_bubble
./obj_dir/sim_bubble
